/* Makefile */
# Verilator flow for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* icache_ctrl.sv */
/*
 * Instruction cache controller. Runs the two fetch pipeline stages, picks
 * the refill victim, reads the line over AXI4-Lite and replays the miss.
 */
`timescale 1ns/1ps

module icache_ctrl
	import icache_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   fetch_valid,
	input  fetch_addr_u            fetch_addr,
	output logic                   fetch_ready,
	output logic                   fetch_rvalid,
	output logic [31:0]            fetch_data,
	output fetch_addr_u            lookup_addr,
	output logic                   lookup_en,
	input  logic                   hit,
	input  way_t                   hit_way,
	input  logic [WAYS-1:0]        valids,
	input  logic [WAYS-1:0][31:0]  rd_words,
	output logic                   fill_en,
	output logic                   fill_last,
	output way_t                   fill_way,
	output fetch_addr_u            fill_addr,
	output logic [31:0]            fill_data,
	output logic [ADDR_W-1:0]      araddr,
	output logic                   arvalid,
	input  logic                   arready,
	input  logic [31:0]            rdata,
	input  logic                   rvalid,
	output logic                   rready
);

	logic [1:0]       state;
	logic             a_valid;
	logic             b_valid;
	fetch_addr_u      a_addr;
	fetch_addr_u      b_addr;
	logic             miss;
	logic             stall;
	logic             last_beat;
	logic [OFS_W-3:0] beat;
	way_t [LINES-1:0] rr_ptr;
	way_t             victim;

	// ====================
	// Fetch pipeline
	// ====================

	// Stage B missed when its registered lookup came back without a hit
	assign miss = (state == ST_IDLE) && b_valid && !hit;
	// Anything but a clean idle cycle freezes both stages
	assign stall = (state != ST_IDLE) || miss;
	assign fetch_ready = !stall;

	// Stage A is looked up normally, stage B while a miss is handled
	// The stalled address also feeds the valid bits for the victim choice
	assign lookup_addr = stall ? b_addr : a_addr;
	assign lookup_en = (!stall && a_valid) || (state == ST_REPLAY);

	// Stage B answers one cycle after its lookup
	assign fetch_rvalid = (state == ST_IDLE) && b_valid && hit;
	assign fetch_data = rd_words[hit_way];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			a_valid <= 1'b0;
			b_valid <= 1'b0;
		end
		else if (!stall)
		begin
			a_valid <= fetch_valid;
			b_valid <= a_valid;
		end
	end

	// Addresses move along with the valid bits, the victim is latched
	// in the cycle the miss shows up
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			if (fetch_valid)
				a_addr <= fetch_addr;
			b_addr <= a_addr;
		end
		if (miss)
			fill_way <= victim;
	end

	// ====================
	// Victim choice
	// ====================

	// Lowest numbered invalid way first, else the round robin pointer
	always_comb
	begin
		victim = rr_ptr[b_addr.f.index];
		for (int w = WAYS - 1; w >= 0; w--)
		begin
			if (!valids[w])
				victim = way_t'(w);
		end
	end

	// ====================
	// Refill read master
	// ====================

	// Line-aligned address of the current beat
	always_comb
	begin
		fill_addr = b_addr;
		fill_addr.f.word = beat;
		fill_addr.f.byte_sel = '0;
	end

	assign araddr = fill_addr.raw;
	assign arvalid = (state == ST_ADDR);
	assign rready = (state == ST_DATA);
	assign last_beat = (beat == (OFS_W-2)'(LINE_WORDS - 1));

	// Each accepted R beat is written straight into the arrays
	assign fill_en = rready && rvalid;
	assign fill_last = fill_en && last_beat;
	assign fill_data = rdata;

	// One read in flight, address phase then data phase per word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			beat <= '0;
			rr_ptr <= '0;
		end
		else
		begin
			case (state)
			ST_IDLE:
				if (miss)
				begin
					state <= ST_ADDR;
					beat <= '0;
					// Pointer only moves when it actually chose the victim
					if (&valids)
						rr_ptr[b_addr.f.index] <= rr_ptr[b_addr.f.index] + 2'd1;
				end
			ST_ADDR:
				if (arready)
					state <= ST_DATA;
			ST_DATA:
				if (rvalid)
				begin
					beat <= beat + 1'b1;
					state <= last_beat ? ST_REPLAY : ST_ADDR;
				end
			ST_REPLAY:
				// Stage B is compared again here and answers next cycle
				state <= ST_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* icache_data_array.sv */
/*
 * Line data store of the instruction cache. Reads the addressed word of
 * all four ways in one registered stage and takes one refill word per beat.
 */
`timescale 1ns/1ps

module icache_data_array
	import icache_pkg::*;
(
	input  logic                   clk,
	input  logic                   rd_en,
	input  fetch_addr_u            rd_addr,
	input  logic                   wr_en,
	input  way_t                   wr_way,
	input  fetch_addr_u            wr_addr,
	input  logic [31:0]            wr_data,
	output logic [WAYS-1:0][31:0]  rd_words
);

	// Word storage per way, addressed by set index and word in line
	logic [31:0] mem [WAYS][LINES*LINE_WORDS];

	// Word pointers built from the index and word fields
	logic [IDX_W+OFS_W-3:0] rd_ptr;
	logic [IDX_W+OFS_W-3:0] wr_ptr;

	assign rd_ptr = {rd_addr.f.index, rd_addr.f.word};
	assign wr_ptr = {wr_addr.f.index, wr_addr.f.word};

	// All ways are read at once, the way is picked after the tag compare
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			for (int w = 0; w < WAYS; w++)
				rd_words[w] <= mem[w][rd_ptr];
		end
	end

	// One word per R beat into the victim way
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_way][wr_ptr] <= wr_data;
	end

endmodule

/* icache_hit_detect.sv */
/*
 * Hit detector. Compares the tags of all four ways against the lookup
 * address, qualifies each match by its valid bit and registers the result.
 */
`timescale 1ns/1ps

module icache_hit_detect
	import icache_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        lookup_en,
	input  fetch_addr_u                 addr,
	input  logic [WAYS-1:0][TAG_W-1:0]  tags,
	input  logic [WAYS-1:0]             valids,
	output logic                        hit,
	output way_t                        hit_way
);

	// One match bit per way
	logic [WAYS-1:0] match;
	// Way to be registered with the next lookup
	way_t way_nxt;

	// ====================
	// Compare
	// ====================

	// A way matches only when its tag is equal and its line is valid
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
			match[w] = valids[w] && (tags[w] == addr.f.tag);
	end

	// Encode the matching way; at most one way can hold a given tag
	// If nothing matches the last way is kept
	always_comb
	begin
		way_nxt = hit_way;
		for (int w = 0; w < WAYS; w++)
		begin
			if (match[w])
				way_nxt = way_t'(w);
		end
	end

	// ====================
	// Result registers
	// ====================

	// Hit flag is updated only by a real lookup so it stays tied to
	// the request that moved into stage B
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hit <= 1'b0;
		else if (lookup_en)
			hit <= |match;
	end

	// Way number of the matching line, held across lookups that miss
	always_ff @(posedge clk)
	begin
		if (lookup_en)
			hit_way <= way_nxt;
	end

endmodule

/* icache_pkg.sv */
/*
 * Instruction cache package. Cache geometry, controller state encodings,
 * the fetch address union and the way number type.
 */
package icache_pkg;

	// ====================
	// Geometry
	// ====================

	// Byte address width of the fetch port and the AXI read channel
	localparam int ADDR_W = 32;
	// Four ways per set
	localparam int WAYS = 4;
	// Sets per way
	localparam int LINES = 64;
	// 32-bit words per 16-byte line
	localparam int LINE_WORDS = 4;
	localparam int IDX_W = 6;
	// Byte offset inside a line, the upper two bits select the word
	localparam int OFS_W = 4;
	localparam int TAG_W = 22;

	// ====================
	// Controller states
	// ====================

	// Idle runs the hit pipeline, the other three belong to a refill
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_REPLAY = 2'd3;

	// ====================
	// Types
	// ====================

	// Way number within a set
	typedef logic [1:0] way_t;

	// Fetch address, seen as a raw byte address or split for the lookup
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [IDX_W-1:0] index;
			logic [OFS_W-3:0] word;
			logic [1:0]       byte_sel;
		} f;
	} fetch_addr_u;

endpackage

/* icache_tag_array.sv */
/*
 * Tag store of the instruction cache. One tag and one valid bit per way
 * and set, a combinational read of the whole set and a one-way refill write.
 */
`timescale 1ns/1ps

module icache_tag_array
	import icache_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [IDX_W-1:0]            rd_index,
	input  logic                        wr_en,
	input  way_t                        wr_way,
	input  logic [IDX_W-1:0]            wr_index,
	input  logic [TAG_W-1:0]            wr_tag,
	output logic [WAYS-1:0][TAG_W-1:0]  tags,
	output logic [WAYS-1:0]             valids
);

	// Tag storage, one entry per way and set
	logic [TAG_W-1:0] tag_mem [WAYS][LINES];
	// Valid bits, one vector of sets per way
	logic [WAYS-1:0][LINES-1:0] valid_q;

	// ====================
	// Set read
	// ====================

	// All four ways of the addressed set are presented in the same cycle
	// so the hit detector can compare them in parallel
	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
		begin
			tags[w] = tag_mem[w][rd_index];
			valids[w] = valid_q[w][rd_index];
		end
	end

	// ====================
	// Refill write
	// ====================

	// The tag goes in with the last beat of a line refill
	always_ff @(posedge clk)
	begin
		if (wr_en)
			tag_mem[wr_way][wr_index] <= wr_tag;
	end

	// A line only becomes valid once all of its words are in the data array
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_q <= '0;
		else if (wr_en)
			valid_q[wr_way][wr_index] <= 1'b1;
	end

endmodule

/* icache_top.sv */
/*
 * Four-way set-associative instruction cache. Ties the tag store, the hit
 * detector, the data store and the controller to the fetch and AXI ports.
 */
`timescale 1ns/1ps

module icache_top
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               fetch_valid,
	input  fetch_addr_u        fetch_addr,
	output logic               fetch_ready,
	output logic               fetch_rvalid,
	output logic [31:0]        fetch_data,
	output logic [ADDR_W-1:0]  araddr,
	output logic               arvalid,
	input  logic               arready,
	input  logic [31:0]        rdata,
	input  logic               rvalid,
	output logic               rready
);

	// Lookup path
	fetch_addr_u               lookup_addr;
	logic                      lookup_en;
	logic [WAYS-1:0][TAG_W-1:0] tags;
	logic [WAYS-1:0]           valids;
	logic                      hit;
	way_t                      hit_way;
	logic [WAYS-1:0][31:0]     rd_words;

	// Refill path
	logic                      fill_en;
	logic                      fill_last;
	way_t                      fill_way;
	fetch_addr_u               fill_addr;
	logic [31:0]               fill_data;

	// ====================
	// Storage
	// ====================

	// Tag and valid write happen once per line, with the last beat
	icache_tag_array tag_array0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_index (lookup_addr.f.index),
		.wr_en    (fill_last),
		.wr_way   (fill_way),
		.wr_index (fill_addr.f.index),
		.wr_tag   (fill_addr.f.tag),
		.tags     (tags),
		.valids   (valids)
	);

	// Data words are written on every beat
	icache_data_array data_array0 (
		.clk      (clk),
		.rd_en    (lookup_en),
		.rd_addr  (lookup_addr),
		.wr_en    (fill_en),
		.wr_way   (fill_way),
		.wr_addr  (fill_addr),
		.wr_data  (fill_data),
		.rd_words (rd_words)
	);

	// ====================
	// Lookup and control
	// ====================

	icache_hit_detect hit_detect0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.lookup_en (lookup_en),
		.addr      (lookup_addr),
		.tags      (tags),
		.valids    (valids),
		.hit       (hit),
		.hit_way   (hit_way)
	);

	icache_ctrl ctrl0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_valid  (fetch_valid),
		.fetch_addr   (fetch_addr),
		.fetch_ready  (fetch_ready),
		.fetch_rvalid (fetch_rvalid),
		.fetch_data   (fetch_data),
		.lookup_addr  (lookup_addr),
		.lookup_en    (lookup_en),
		.hit          (hit),
		.hit_way      (hit_way),
		.valids       (valids),
		.rd_words     (rd_words),
		.fill_en      (fill_en),
		.fill_last    (fill_last),
		.fill_way     (fill_way),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready)
	);

endmodule

/* tb.f */
icache_pkg.sv
icache_tag_array.sv
icache_hit_detect.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
/*
 * Testbench for the instruction cache. Fetches come from a fixed-seed LFSR,
 * an AXI4-Lite memory model answers the refills and a set model predicts hits.
 */
`timescale 1ns/1ps

module tb_icache
	import icache_pkg::*;
();

	localparam int NUM_TESTS = 4;
	localparam int MAX_REQS = 200;
	// Worst case of about 40 cycles per request over all tests
	localparam int LIMIT_NS = NUM_TESTS * MAX_REQS * 40 * 100;

	logic              clk;
	logic              rst_n;
	logic              fetch_valid;
	fetch_addr_u       fetch_addr;
	logic              fetch_ready;
	logic              fetch_rvalid;
	logic [31:0]       fetch_data;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [31:0]       rdata;
	logic              rvalid;
	logic              rready;

	logic [31:0] lfsr;
	int          cyc;
	int          errors;
	int          accepted;
	int          responses;
	int          last_resp;
	int          ar_seen;
	int          ar_total;
	bit          delays_on;

	// Accepted requests, oldest first, with the model's prediction
	fetch_addr_u req_addr [$];
	bit          req_hit [$];
	int          req_cyc [$];
	int          req_ar [$];
	// AR addresses the model expects, in issue order
	fetch_addr_u exp_ar [$];

	// Set model with tags, valid bits and round robin pointers
	logic [TAG_W-1:0] m_tag [LINES][WAYS];
	bit               m_valid [LINES][WAYS];
	int               m_rr [LINES];

	// AXI4-Lite slave state, one read in flight
	bit          r_pending;
	logic [31:0] r_addr;
	int          r_wait;
	int          ar_wait;

	icache_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_valid  (fetch_valid),
		.fetch_addr   (fetch_addr),
		.fetch_ready  (fetch_ready),
		.fetch_rvalid (fetch_rvalid),
		.fetch_data   (fetch_data),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Models
	// ====================

	// Galois LFSR, stepped once for every bit taken
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(next_bit());
		return v;
	endfunction

	// Handshake delay of 0 to 3 cycles, or none in the fast tests
	function automatic int pick_delay();
		int d;
		d = 0;
		if (delays_on)
			d = take_bits(2);
		return d;
	endfunction

	// Memory content is the address with its bits reversed
	function automatic logic [31:0] mem_word(logic [31:0] addr);
		logic [31:0] w;
		for (int i = 0; i < 32; i++)
			w[i] = addr[31 - i];
		return w;
	endfunction

	function automatic fetch_addr_u pool_addr(int tag, int index, int word);
		fetch_addr_u a;
		a.raw = '0;
		a.f.tag = TAG_W'(tag);
		a.f.index = IDX_W'(index);
		a.f.word = (OFS_W-2)'(word);
		return a;
	endfunction

	// Looks a request up in the set model and fills the line on a miss
	// Victim is the lowest invalid way, else the set pointer which then moves
	function automatic bit model_lookup(fetch_addr_u a);
		int set;
		int v;
		bit found;
		set = int'(a.f.index);
		found = 1'b0;
		for (int w = 0; w < WAYS; w++)
		begin
			if (m_valid[set][w] && m_tag[set][w] == a.f.tag)
				found = 1'b1;
		end
		if (!found)
		begin
			v = -1;
			for (int w = WAYS - 1; w >= 0; w--)
			begin
				if (!m_valid[set][w])
					v = w;
			end
			if (v < 0)
			begin
				v = m_rr[set];
				m_rr[set] = (m_rr[set] + 1) % WAYS;
			end
			m_valid[set][v] = 1'b1;
			m_tag[set][v] = a.f.tag;
		end
		return found;
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_araddr(fetch_addr_u got, fetch_addr_u exp);
		if (got.raw !== exp.raw)
		begin
			$display("FAILED t=%0t araddr got %h exp %h", $time, got.raw, exp.raw);
			errors++;
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
		begin
			$display("FAILED t=%0t %s got %0d exp %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_level(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// ====================
	// Bus activity
	// ====================

	// A hit answers two falling edges after it was driven, or right behind
	// the previous response when it sat frozen behind a miss
	task automatic check_response();
		fetch_addr_u a;
		bit hit;
		int acc;
		int need;
		int exp_cyc;
		if (fetch_rvalid)
		begin
			// Every response is counted, also one that no request explains
			responses++;
			if (req_addr.size() == 0)
			begin
				$display("Error at %0t: response with no request outstanding", $time);
				errors++;
			end
			else
			begin
				a = req_addr.pop_front();
				hit = req_hit.pop_front();
				acc = req_cyc.pop_front();
				need = req_ar.pop_front();
				check_word("fetch_data", fetch_data, mem_word(a.raw));
				if (hit)
				begin
					exp_cyc = acc + 2;
					if (last_resp + 1 > exp_cyc)
						exp_cyc = last_resp + 1;
					check_count("response cycle", cyc, exp_cyc);
				end
				// All reads of this request, and none of a later one, are done
				check_count("ar transfers", ar_seen, need);
				last_resp = cyc;
			end
		end
	endtask

	task automatic record_ar(fetch_addr_u got);
		ar_seen++;
		if (exp_ar.size() == 0)
		begin
			$display("Error at %0t: AR transfer at %h that no miss explains", $time, got.raw);
			errors++;
		end
		else
			check_araddr(got, exp_ar.pop_front());
	endtask

	// Handshakes decided here complete at the next rising edge
	task automatic serve_axi();
		fetch_addr_u got;
		rvalid = 1'b0;
		arready = 1'b0;
		if (r_pending)
		begin
			if (r_wait > 0)
				r_wait--;
			else
			begin
				// rvalid stays up until the master takes the beat
				rvalid = 1'b1;
				rdata = mem_word(r_addr);
				if (rready)
					r_pending = 1'b0;
			end
		end
		else if (arvalid)
		begin
			if (ar_wait > 0)
				ar_wait--;
			else
			begin
				arready = 1'b1;
				got.raw = araddr;
				record_ar(got);
				r_pending = 1'b1;
				r_addr = araddr;
				r_wait = pick_delay();
				ar_wait = pick_delay();
			end
		end
	endtask

	// One cycle; outputs are stable at the falling edge where inputs change
	task automatic step();
		@(negedge clk);
		cyc++;
		check_response();
		serve_axi();
		fetch_valid = 1'b0;
	endtask

	// Holds the request until fetch_ready takes it at the next rising edge
	task automatic send(fetch_addr_u a);
		bit done;
		done = 1'b0;
		while (!done)
		begin
			step();
			fetch_valid = 1'b1;
			fetch_addr = a;
			if (fetch_ready)
			begin
				done = 1'b1;
				req_hit.push_back(model_lookup(a));
				if (!req_hit[$])
				begin
					for (int k = 0; k < LINE_WORDS; k++)
						exp_ar.push_back(pool_addr(a.f.tag, a.f.index, k));
					ar_total += LINE_WORDS;
				end
				req_addr.push_back(a);
				req_cyc.push_back(cyc);
				req_ar.push_back(ar_total);
				accepted++;
			end
		end
	endtask

	task automatic end_test(int num, string name, int start_errors);
		while (req_addr.size() > 0)
			step();
		repeat (4) step();
		$display("test %0d %s: %0d errors", num, name, errors - start_errors);
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		int e;
		int t;
		int s;
		int w;
		int revisit [6];
		lfsr = 32'hc32c;
		rst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		{cyc, errors, accepted, responses, last_resp, ar_seen, ar_total} = '0;
		{r_pending, r_addr, r_wait, ar_wait} = '0;
		delays_on = 1'b1;
		for (int i = 0; i < LINES; i++)
		begin
			m_rr[i] = 0;
			for (int j = 0; j < WAYS; j++)
				m_valid[i][j] = 1'b0;
		end
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Idle levels right after reset
		e = errors;
		step();
		check_level("fetch_rvalid", fetch_rvalid, 1'b0);
		check_level("arvalid", arvalid, 1'b0);
		check_level("rready", rready, 1'b0);
		check_level("fetch_ready", fetch_ready, 1'b1);
		end_test(1, "reset levels", e);

		// Four sets and eight tags, so lines get evicted and fetched again
		e = errors;
		for (int i = 0; i < MAX_REQS; i++)
		begin
			if (take_bits(1) == 1)
				step();
			t = take_bits(3);
			s = take_bits(2);
			w = take_bits(2);
			send(pool_addr(t, s, w));
		end
		end_test(2, "random fetch", e);

		// Six tags into one set, then a mix of kept and evicted tags
		e = errors;
		revisit = '{105, 104, 100, 103, 102, 101};
		for (int i = 0; i < 6; i++)
			send(pool_addr(100 + i, 9, i % LINE_WORDS));
		for (int i = 0; i < 6; i++)
			send(pool_addr(revisit[i], 9, 3));
		end_test(3, "set eviction", e);

		// Two lines loaded, then hits on every cycle with no delays
		e = errors;
		delays_on = 1'b0;
		send(pool_addr(7, 20, 0));
		send(pool_addr(8, 21, 1));
		while (req_addr.size() > 0)
			step();
		for (int i = 0; i < 16; i++)
			send(pool_addr(7 + (i % 2), 20 + (i % 2), i % LINE_WORDS));
		end_test(4, "back-to-back hits", e);

		check_count("responses", responses, accepted);
		check_count("unissued ar transfers", exp_ar.size(), 0);
		$display("tests %0d, accepted %0d, responses %0d, errors %0d",
			NUM_TESTS, accepted, responses, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Ends a run in which some handshake never completed
	initial
	begin
		#(LIMIT_NS);
		$display("Error: watchdog expired after %0d ns with requests outstanding", LIMIT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
